/* Makefile */
VERILATOR  ?= verilator
TOP        := b2s_wr_tb
RTL_TOP    := b2s_wr_top
FLIST      := flist.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/b2s_b_resp.sv */
`timescale 1ns/1ps

module b2s_b_resp import b2s_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              b_push,
  input  logic [ID_W-1:0]   push_id,
  input  logic [LEN_W-1:0]  push_len,
  output logic              b_full,
  input  logic              lite_bvalid,
  input  logic [RESP_W-1:0] lite_bresp,
  output logic              lite_bready,
  output logic [ID_W-1:0]   s_bid,
  output logic [RESP_W-1:0] s_bresp,
  output logic              s_bvalid,
  input  logic              s_bready
);

  logic [ID_W-1:0]    id_q  [B_DEPTH];
  logic [LEN_W-1:0]   len_q [B_DEPTH];
  logic [B_PTR_W-1:0] wr_ptr;
  logic [B_PTR_W-1:0] rd_ptr;
  logic [B_CNT_W-1:0] q_count;
  logic [LEN_W:0]     beat_cnt;
  logic [RESP_W-1:0]  worst;
  logic               resp_done;
  logic               lite_hs;
  logic               s_hs;

  // Head burst has all its Lite responses.
  assign resp_done = (q_count != '0) && (beat_cnt == {1'b0, len_q[rd_ptr]} + 1'b1);

  assign lite_hs = lite_bvalid && lite_bready;
  assign s_hs    = s_bvalid && s_bready;

  // ##################################################
  // Burst queue
  // ##################################################
  always_ff @(posedge clk) begin
    if (b_push) begin
      id_q[wr_ptr]  <= push_id;
      len_q[wr_ptr] <= push_len;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      q_count <= '0;
    end else begin
      if (b_push) wr_ptr <= wr_ptr + 1'b1;
      if (s_hs) rd_ptr <= rd_ptr + 1'b1;
      q_count <= q_count + B_CNT_W'(b_push) - B_CNT_W'(s_hs);
    end
  end

  // ##################################################
  // Beat count and worst response
  // ##################################################
  always_ff @(posedge clk) begin
    if (reset || s_hs) begin
      beat_cnt <= '0;
      worst    <= RESP_OKAY;
    end else if (lite_hs) begin
      beat_cnt <= beat_cnt + 1'b1;
      if (lite_bresp > worst) worst <= lite_bresp;
    end
  end

  assign b_full      = (q_count == B_CNT_W'(B_DEPTH));
  assign lite_bready = !resp_done;   // Hold off while merged B waits.
  assign s_bvalid    = resp_done;
  assign s_bid       = id_q[rd_ptr];
  assign s_bresp     = worst;

endmodule

/* design/b2s_incr_cmd.sv */
`timescale 1ns/1ps

module b2s_incr_cmd import b2s_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [ADDR_W-1:0] axaddr,
  input  logic [LEN_W-1:0]  axlen,
  input  logic              a_push,
  input  logic              next,
  output logic [ADDR_W-1:0] cmd_addr,
  output logic              next_pending
);

  logic [ADDR_W-1:0] addr_q;
  logic [LEN_W-1:0]  beats_left;
  logic [ADDR_W-1:0] aligned_addr;

  // Drop the byte offset within a beat.
  assign aligned_addr = axaddr & ~ADDR_W'(BEAT_BYTES - 1);

  // ##################################################
  // Beat address
  // ##################################################
  always_ff @(posedge clk) begin
    if (a_push) begin
      addr_q <= aligned_addr;
    end else if (next) begin
      addr_q <= addr_q + ADDR_W'(BEAT_BYTES);   // INCR step.
    end
  end

  // ##################################################
  // Remaining beats
  // ##################################################
  always_ff @(posedge clk) begin
    if (reset) begin
      beats_left <= '0;
    end else if (a_push) begin
      beats_left <= axlen;
    end else if (next) begin
      beats_left <= beats_left - 1'b1;   // Wraps after last beat, reloaded anyway.
    end
  end

  assign cmd_addr     = addr_q;
  assign next_pending = (beats_left != '0);

endmodule

/* design/b2s_pkg.sv */
package b2s_pkg;

  // ##################################################
  // Bus widths
  // ##################################################
  localparam int ADDR_W     = 12;
  localparam int DATA_W     = 32;
  localparam int STRB_W     = 4;
  localparam int ID_W       = 4;
  localparam int LEN_W      = 4;   // awlen is beats minus one.
  localparam int BEAT_BYTES = 4;

  // Burst response queue, depth a power of two.
  localparam int B_DEPTH = 2;
  localparam int B_PTR_W = $clog2(B_DEPTH);
  localparam int B_CNT_W = $clog2(B_DEPTH + 1);

  // ##################################################
  // Response codes, larger is worse
  // ##################################################
  localparam int RESP_W = 2;
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
  localparam logic [RESP_W-1:0] RESP_EXOKAY = 2'd1;
  localparam logic [RESP_W-1:0] RESP_SLVERR = 2'd2;
  localparam logic [RESP_W-1:0] RESP_DECERR = 2'd3;

  // Write command sequencer states.
  localparam logic [1:0] SM_IDLE         = 2'b00;
  localparam logic [1:0] SM_CMD_EN       = 2'b01;
  localparam logic [1:0] SM_CMD_ACCEPTED = 2'b10;
  localparam logic [1:0] SM_DONE_WAIT    = 2'b11;

endpackage

/* design/b2s_wr_cmd_fsm.sv */
`timescale 1ns/1ps

module b2s_wr_cmd_fsm import b2s_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic s_awvalid,
  output logic s_awready,
  output logic m_awvalid,
  input  logic m_awready,
  output logic next,
  input  logic next_pending,
  output logic b_push,
  input  logic b_full,
  output logic a_push
);

  logic [1:0] state;
  logic [1:0] next_state;
  logic       burst_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= SM_IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      SM_IDLE: begin
        if (s_awvalid) begin
          next_state = SM_CMD_EN;
        end
      end
      SM_CMD_EN: begin
        if (m_awready && next_pending) begin
          next_state = SM_CMD_ACCEPTED;
        end else if (m_awready && b_full) begin
          next_state = SM_DONE_WAIT;   // Last beat, no room for B.
        end else if (m_awready) begin
          next_state = SM_IDLE;
        end
      end
      SM_CMD_ACCEPTED: next_state = SM_CMD_EN;
      SM_DONE_WAIT: begin
        if (!b_full) begin
          next_state = SM_IDLE;
        end
      end
      default: next_state = SM_IDLE;
    endcase
  end

  // Leaving CMD_EN or DONE_WAIT for IDLE ends the burst.
  assign burst_done = ((state == SM_CMD_EN) || (state == SM_DONE_WAIT)) &&
                      (next_state == SM_IDLE);

  assign m_awvalid = (state == SM_CMD_EN);
  assign a_push    = (state == SM_IDLE);
  assign next      = (state == SM_CMD_ACCEPTED) || burst_done;
  assign s_awready = burst_done;
  assign b_push    = burst_done;

endmodule

/* design/b2s_wr_port.sv */
`timescale 1ns/1ps

module b2s_wr_port import b2s_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [ID_W-1:0]   s_awid,
  input  logic [ADDR_W-1:0] s_awaddr,
  input  logic [LEN_W-1:0]  s_awlen,
  input  logic              s_awvalid,
  output logic              s_awready,
  input  logic [DATA_W-1:0] s_wdata,
  input  logic [STRB_W-1:0] s_wstrb,
  input  logic              s_wlast,   // Beats are counted from AW instead.
  input  logic              s_wvalid,
  output logic              s_wready,
  output logic [ID_W-1:0]   s_bid,
  output logic [RESP_W-1:0] s_bresp,
  output logic              s_bvalid,
  input  logic              s_bready,
  output logic [ADDR_W-1:0] lite_awaddr,
  output logic              lite_awvalid,
  input  logic              lite_awready,
  output logic [DATA_W-1:0] lite_wdata,
  output logic [STRB_W-1:0] lite_wstrb,
  output logic              lite_wvalid,
  input  logic              lite_wready,
  input  logic [RESP_W-1:0] lite_bresp,
  input  logic              lite_bvalid,
  output logic              lite_bready
);

  logic next;
  logic next_pending;
  logic b_push;
  logic b_full;
  logic a_push;

  b2s_wr_cmd_fsm i_cmd_fsm (
    .clk, .reset, .s_awvalid, .s_awready,
    .m_awvalid(lite_awvalid), .m_awready(lite_awready),
    .next, .next_pending, .b_push, .b_full, .a_push
  );

  b2s_incr_cmd i_incr_cmd (
    .clk, .reset, .axaddr(s_awaddr), .axlen(s_awlen),
    .a_push, .next, .cmd_addr(lite_awaddr), .next_pending
  );

  b2s_b_resp i_b_resp (
    .clk, .reset, .b_push, .push_id(s_awid), .push_len(s_awlen), .b_full,
    .lite_bvalid, .lite_bresp, .lite_bready,
    .s_bid, .s_bresp, .s_bvalid, .s_bready
  );

  // One W beat per Lite write.
  assign lite_wdata  = s_wdata;
  assign lite_wstrb  = s_wstrb;
  assign lite_wvalid = s_wvalid;
  assign s_wready    = lite_wready;

endmodule

/* design/b2s_wr_top.sv */
`timescale 1ns/1ps

module b2s_wr_top import b2s_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [ID_W-1:0]   s0_awid, s1_awid,
  input  logic [ADDR_W-1:0] s0_awaddr, s1_awaddr,
  input  logic [LEN_W-1:0]  s0_awlen, s1_awlen,
  input  logic              s0_awvalid, s1_awvalid,
  output logic              s0_awready, s1_awready,
  input  logic [DATA_W-1:0] s0_wdata, s1_wdata,
  input  logic [STRB_W-1:0] s0_wstrb, s1_wstrb,
  input  logic              s0_wlast, s1_wlast,
  input  logic              s0_wvalid, s1_wvalid,
  output logic              s0_wready, s1_wready,
  output logic [ID_W-1:0]   s0_bid, s1_bid,
  output logic [RESP_W-1:0] s0_bresp, s1_bresp,
  output logic              s0_bvalid, s1_bvalid,
  input  logic              s0_bready, s1_bready,
  output logic [ADDR_W-1:0] m_awaddr,
  output logic              m_awvalid,
  input  logic              m_awready,
  output logic [DATA_W-1:0] m_wdata,
  output logic [STRB_W-1:0] m_wstrb,
  output logic              m_wvalid,
  input  logic              m_wready,
  input  logic [RESP_W-1:0] m_bresp,
  input  logic              m_bvalid,
  output logic              m_bready
);

  // ##################################################
  // Port to arbiter wires
  // ##################################################
  logic [ADDR_W-1:0] p0_awaddr, p1_awaddr;
  logic              p0_awvalid, p1_awvalid;
  logic              p0_awready, p1_awready;
  logic [DATA_W-1:0] p0_wdata, p1_wdata;
  logic [STRB_W-1:0] p0_wstrb, p1_wstrb;
  logic              p0_wvalid, p1_wvalid;
  logic              p0_wready, p1_wready;
  logic [RESP_W-1:0] p0_bresp, p1_bresp;
  logic              p0_bvalid, p1_bvalid;
  logic              p0_bready, p1_bready;

  b2s_wr_port i_port0 (
    .clk, .reset,
    .s_awid(s0_awid), .s_awaddr(s0_awaddr), .s_awlen(s0_awlen),
    .s_awvalid(s0_awvalid), .s_awready(s0_awready),
    .s_wdata(s0_wdata), .s_wstrb(s0_wstrb), .s_wlast(s0_wlast),
    .s_wvalid(s0_wvalid), .s_wready(s0_wready),
    .s_bid(s0_bid), .s_bresp(s0_bresp), .s_bvalid(s0_bvalid), .s_bready(s0_bready),
    .lite_awaddr(p0_awaddr), .lite_awvalid(p0_awvalid), .lite_awready(p0_awready),
    .lite_wdata(p0_wdata), .lite_wstrb(p0_wstrb),
    .lite_wvalid(p0_wvalid), .lite_wready(p0_wready),
    .lite_bresp(p0_bresp), .lite_bvalid(p0_bvalid), .lite_bready(p0_bready)
  );

  b2s_wr_port i_port1 (
    .clk, .reset,
    .s_awid(s1_awid), .s_awaddr(s1_awaddr), .s_awlen(s1_awlen),
    .s_awvalid(s1_awvalid), .s_awready(s1_awready),
    .s_wdata(s1_wdata), .s_wstrb(s1_wstrb), .s_wlast(s1_wlast),
    .s_wvalid(s1_wvalid), .s_wready(s1_wready),
    .s_bid(s1_bid), .s_bresp(s1_bresp), .s_bvalid(s1_bvalid), .s_bready(s1_bready),
    .lite_awaddr(p1_awaddr), .lite_awvalid(p1_awvalid), .lite_awready(p1_awready),
    .lite_wdata(p1_wdata), .lite_wstrb(p1_wstrb),
    .lite_wvalid(p1_wvalid), .lite_wready(p1_wready),
    .lite_bresp(p1_bresp), .lite_bvalid(p1_bvalid), .lite_bready(p1_bready)
  );

  lite_wr_arbiter i_arbiter (.*);

endmodule

/* design/lite_wr_arbiter.sv */
`timescale 1ns/1ps

module lite_wr_arbiter import b2s_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic [ADDR_W-1:0] p0_awaddr,
  input  logic              p0_awvalid,
  output logic              p0_awready,
  input  logic [DATA_W-1:0] p0_wdata,
  input  logic [STRB_W-1:0] p0_wstrb,
  input  logic              p0_wvalid,
  output logic              p0_wready,
  output logic [RESP_W-1:0] p0_bresp,
  output logic              p0_bvalid,
  input  logic              p0_bready,
  input  logic [ADDR_W-1:0] p1_awaddr,
  input  logic              p1_awvalid,
  output logic              p1_awready,
  input  logic [DATA_W-1:0] p1_wdata,
  input  logic [STRB_W-1:0] p1_wstrb,
  input  logic              p1_wvalid,
  output logic              p1_wready,
  output logic [RESP_W-1:0] p1_bresp,
  output logic              p1_bvalid,
  input  logic              p1_bready,
  output logic [ADDR_W-1:0] m_awaddr,
  output logic              m_awvalid,
  input  logic              m_awready,
  output logic [DATA_W-1:0] m_wdata,
  output logic [STRB_W-1:0] m_wstrb,
  output logic              m_wvalid,
  input  logic              m_wready,
  input  logic [RESP_W-1:0] m_bresp,
  input  logic              m_bvalid,
  output logic              m_bready
);

  logic busy;
  logic sel;
  logic prio;       // Port favoured on the next grant.
  logic aw_done;
  logic w_done;
  logic gnt_sel;
  logic cur_sel;
  logic req_any;
  logic aw_open;
  logic w_open;
  logic b_hs;

  // ##################################################
  // Grant
  // ##################################################
  assign req_any = p0_awvalid || p1_awvalid;
  assign gnt_sel = p1_awvalid && (prio || !p0_awvalid);
  assign cur_sel = busy ? sel : gnt_sel;   // Same-cycle grant when idle.
  assign aw_open = (busy || req_any) && !aw_done;
  assign w_open  = (busy || req_any) && !w_done;
  assign b_hs    = m_bvalid && m_bready;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy    <= 1'b0;
      sel     <= 1'b0;
      prio    <= 1'b0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
    end else if (b_hs) begin
      busy    <= 1'b0;
      aw_done <= 1'b0;
      w_done  <= 1'b0;
      prio    <= !sel;
    end else begin
      if (!busy && req_any) begin
        busy <= 1'b1;
        sel  <= gnt_sel;
      end
      if (m_awvalid && m_awready) aw_done <= 1'b1;
      if (m_wvalid && m_wready) w_done <= 1'b1;
    end
  end

  // ##################################################
  // Routing
  // ##################################################
  assign m_awaddr  = cur_sel ? p1_awaddr : p0_awaddr;
  assign m_awvalid = aw_open && (cur_sel ? p1_awvalid : p0_awvalid);
  assign m_wdata   = cur_sel ? p1_wdata : p0_wdata;
  assign m_wstrb   = cur_sel ? p1_wstrb : p0_wstrb;
  assign m_wvalid  = w_open && (cur_sel ? p1_wvalid : p0_wvalid);
  assign m_bready  = busy && (sel ? p1_bready : p0_bready);

  assign p0_awready = aw_open && !cur_sel && m_awready;
  assign p1_awready = aw_open && cur_sel && m_awready;
  assign p0_wready  = w_open && !cur_sel && m_wready;
  assign p1_wready  = w_open && cur_sel && m_wready;
  assign p0_bvalid  = busy && !sel && m_bvalid;
  assign p1_bvalid  = busy && sel && m_bvalid;
  assign p0_bresp   = m_bresp;
  assign p1_bresp   = m_bresp;

endmodule

/* flist.f */
design/b2s_pkg.sv
design/b2s_wr_cmd_fsm.sv
design/b2s_incr_cmd.sv
design/b2s_b_resp.sv
design/b2s_wr_port.sv
design/lite_wr_arbiter.sv
design/b2s_wr_top.sv
test/tb_clock.sv
test/b2s_wr_tb.sv

/* test/b2s_wr_tb.sv */
`timescale 1ns/1ps

module b2s_wr_tb import b2s_pkg::*; ();

  localparam int N_ROWS      = 10;
  localparam int TIMEOUT     = 3000;   // Cycles per wait.
  localparam int STALL_CYC   = 20;
  localparam int SIG_AWREADY = 0;
  localparam int SIG_WREADY  = 1;
  localparam int SIG_BVALID  = 2;

  // ##################################################
  // Bursts: port, id, address, awlen, bready stall, SLVERR beat, expected bresp
  // ##################################################
  int tbl_port  [N_ROWS] = '{0, 1, 0, 1, 0, 1, 0, 0, 1, 0};
  int tbl_id    [N_ROWS] = '{1, 2, 3, 4, 5, 6, 7, 8, 9, 10};
  int tbl_addr  [N_ROWS] = '{'h006, 'h800, 'h040, 'h900, 'h100,
                             'hA00, 'h200, 'h240, 'hB00, 'h300};
  int tbl_len   [N_ROWS] = '{0, 3, 7, 0, 2, 15, 1, 0, 2, 3};
  int tbl_stall [N_ROWS] = '{0, 0, 0, 0, 0, 0, 1, 0, 0, 0};
  int tbl_err   [N_ROWS] = '{-1, -1, 2, 0, -1, -1, -1, -1, 1, -1};
  logic [RESP_W-1:0] tbl_bresp [N_ROWS] = '{RESP_OKAY, RESP_OKAY, RESP_SLVERR, RESP_SLVERR,
      RESP_OKAY, RESP_OKAY, RESP_OKAY, RESP_OKAY, RESP_SLVERR, RESP_OKAY};

  logic              clk;
  logic              reset;
  logic [ID_W-1:0]   awid    [2];
  logic [ADDR_W-1:0] awaddr  [2];
  logic [LEN_W-1:0]  awlen   [2];
  logic              awvalid [2];
  logic              awready [2];
  logic [DATA_W-1:0] wdata   [2];
  logic [STRB_W-1:0] wstrb   [2];
  logic              wlast   [2];
  logic              wvalid  [2];
  logic              wready  [2];
  logic [ID_W-1:0]   bid     [2];
  logic [RESP_W-1:0] bresp   [2];
  logic              bvalid  [2];
  logic              bready  [2];
  logic [ADDR_W-1:0] m_awaddr;
  logic              m_awvalid;
  logic              m_awready;
  logic [DATA_W-1:0] m_wdata;
  logic [STRB_W-1:0] m_wstrb;
  logic              m_wvalid;
  logic              m_wready;
  logic [RESP_W-1:0] m_bresp;
  logic              m_bvalid;
  logic              m_bready;
  logic [31:0]       lfsr = 32'd32;
  logic [47:0]       exp_w0 [$];   // {addr, data, strb} per port.
  logic [47:0]       exp_w1 [$];
  logic [47:0]       wr_log [$];

  tb_clock i_clock (.clk);

  b2s_wr_top i_b2s_wr_top (
    .clk, .reset,
    .s0_awid(awid[0]), .s0_awaddr(awaddr[0]), .s0_awlen(awlen[0]),
    .s0_awvalid(awvalid[0]), .s0_awready(awready[0]),
    .s0_wdata(wdata[0]), .s0_wstrb(wstrb[0]), .s0_wlast(wlast[0]),
    .s0_wvalid(wvalid[0]), .s0_wready(wready[0]),
    .s0_bid(bid[0]), .s0_bresp(bresp[0]), .s0_bvalid(bvalid[0]), .s0_bready(bready[0]),
    .s1_awid(awid[1]), .s1_awaddr(awaddr[1]), .s1_awlen(awlen[1]),
    .s1_awvalid(awvalid[1]), .s1_awready(awready[1]),
    .s1_wdata(wdata[1]), .s1_wstrb(wstrb[1]), .s1_wlast(wlast[1]),
    .s1_wvalid(wvalid[1]), .s1_wready(wready[1]),
    .s1_bid(bid[1]), .s1_bresp(bresp[1]), .s1_bvalid(bvalid[1]), .s1_bready(bready[1]),
    .m_awaddr, .m_awvalid, .m_awready, .m_wdata, .m_wstrb, .m_wvalid, .m_wready,
    .m_bresp, .m_bvalid, .m_bready
  );

  // Galois LFSR, one step per bit taken.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
  endfunction

  function automatic logic is_err_addr(input logic [ADDR_W-1:0] a);
    logic hit;
    int   r;
    hit = 1'b0;
    for (r = 0; r < N_ROWS; r++) begin
      if (tbl_err[r] >= 0 &&
          a == (ADDR_W'(tbl_addr[r]) & ~ADDR_W'(3)) + ADDR_W'(4 * tbl_err[r])) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [47:0] exp, input logic [47:0] act);
    if (exp !== act) begin
      fail_run($sformatf("ERR %s expected %h actual %h", name, exp, act));
    end
  endtask

  // Returns at the falling edge where the signal is seen high.
  task automatic wait_for(input int p, input int which, input string what);
    int n;
    n = 0;
    forever begin
      @(negedge clk);
      if ((which == SIG_AWREADY && awready[p]) || (which == SIG_WREADY && wready[p]) ||
          (which == SIG_BVALID && bvalid[p])) begin
        break;
      end
      n++;
      if (n > TIMEOUT) fail_run($sformatf("Port %0d timed out waiting for %s", p, what));
    end
  endtask

  task automatic issue_burst(input int p, input int r);
    logic [ADDR_W-1:0] base;
    logic [DATA_W-1:0] data [16];
    logic [STRB_W-1:0] strb [16];
    int                k;
    int                kk;
    base = ADDR_W'(tbl_addr[r]) & ~ADDR_W'(3);
    for (k = 0; k <= tbl_len[r]; k++) begin
      data[k] = rand_bits(DATA_W);
      strb[k] = STRB_W'(rand_bits(STRB_W));
      if (p == 0) exp_w0.push_back({base + ADDR_W'(4 * k), data[k], strb[k]});
      else exp_w1.push_back({base + ADDR_W'(4 * k), data[k], strb[k]});
    end
    awid[p]    = ID_W'(tbl_id[r]);
    awaddr[p]  = ADDR_W'(tbl_addr[r]);
    awlen[p]   = LEN_W'(tbl_len[r]);
    awvalid[p] = 1'b1;   // Held for the whole burst.
    fork
      begin
        wait_for(p, SIG_AWREADY, "awready");
        @(posedge clk);
        #2 awvalid[p] = 1'b0;
      end
      begin
        for (kk = 0; kk <= tbl_len[r]; kk++) begin
          wdata[p]  = data[kk];
          wstrb[p]  = strb[kk];
          wlast[p]  = (kk == tbl_len[r]);
          wvalid[p] = 1'b1;
          wait_for(p, SIG_WREADY, "wready");
          @(posedge clk);
          #2;
        end
        wvalid[p] = 1'b0;
      end
    join
  endtask

  task automatic collect_b(input int p, input int r);
    bready[p] = (tbl_stall[r] == 0);
    wait_for(p, SIG_BVALID, "bvalid");
    if (tbl_stall[r] != 0) begin
      repeat (STALL_CYC) @(negedge clk);   // Next burst queues meanwhile.
      @(posedge clk);
      #2 bready[p] = 1'b1;
      @(negedge clk);
      check_val($sformatf("row %0d bvalid held", r), 48'(1), 48'(bvalid[p]));
    end
    check_val($sformatf("row %0d bid", r), 48'(tbl_id[r]), 48'(bid[p]));
    check_val($sformatf("row %0d bresp", r), 48'(tbl_bresp[r]), 48'(bresp[p]));
    @(posedge clk);
    #2;
  endtask

  task automatic run_port(input int p);
    int ri;
    int rb;
    fork
      begin
        for (ri = 0; ri < N_ROWS; ri++) if (tbl_port[ri] == p) issue_burst(p, ri);
      end
      begin
        for (rb = 0; rb < N_ROWS; rb++) if (tbl_port[rb] == p) collect_b(p, rb);
      end
    join
  endtask

  // ##################################################
  // Lite slave model
  // ##################################################
  initial begin : lite_slave
    logic              have_aw;
    logic              have_w;
    logic              bpend;
    logic              in_flight;
    logic [ADDR_W-1:0] aw_addr;
    logic [DATA_W-1:0] w_data;
    logic [STRB_W-1:0] w_strb;
    logic [47:0]       exp;
    have_aw   = 1'b0;
    have_w    = 1'b0;
    bpend     = 1'b0;
    in_flight = 1'b0;
    m_awready = 1'b0;
    m_wready  = 1'b0;
    m_bvalid  = 1'b0;
    m_bresp   = RESP_OKAY;
    forever begin
      @(negedge clk);   // Handshakes of the coming edge.
      if (in_flight && m_awvalid) fail_run("m_awvalid rose before the previous B handshake");
      if (m_awvalid && m_awready) begin
        have_aw   = 1'b1;
        aw_addr   = m_awaddr;
        in_flight = 1'b1;
      end
      if (m_wvalid && m_wready) begin
        have_w = 1'b1;
        w_data = m_wdata;
        w_strb = m_wstrb;
      end
      if (m_bvalid && m_bready) begin
        have_aw   = 1'b0;
        have_w    = 1'b0;
        bpend     = 1'b0;
        in_flight = 1'b0;
      end
      @(posedge clk);
      #2;
      m_awready = !have_aw && (rand_bits(1) != 0);
      m_wready  = !have_w && (rand_bits(1) != 0);
      if (have_aw && have_w && !bpend) begin
        if ((aw_addr[11] ? exp_w1.size() : exp_w0.size()) == 0) begin
          fail_run($sformatf("Lite write to %h that no burst expects", aw_addr));
        end
        exp = aw_addr[11] ? exp_w1.pop_front() : exp_w0.pop_front();
        check_val("Lite write", exp, {aw_addr, w_data, w_strb});
        wr_log.push_back({aw_addr, w_data, w_strb});
        m_bresp = is_err_addr(aw_addr) ? RESP_SLVERR : RESP_OKAY;
        bpend   = 1'b1;
      end
      m_bvalid = bpend;
    end
  end

  // ##################################################
  // Main sequence
  // ##################################################
  initial begin
    int p;
    int r;
    int total;
    reset = 1'b1;
    total = 0;
    for (p = 0; p < 2; p++) begin
      awid[p]    = '0;
      awaddr[p]  = '0;
      awlen[p]   = '0;
      awvalid[p] = 1'b0;
      wdata[p]   = '0;
      wstrb[p]   = '0;
      wlast[p]   = 1'b0;
      wvalid[p]  = 1'b0;
      bready[p]  = 1'b0;
    end
    for (r = 0; r < N_ROWS; r++) total += tbl_len[r] + 1;
    repeat (5) @(posedge clk);
    #2 reset = 1'b0;
    @(negedge clk);
    check_val("idle outputs", 48'(0), 48'({m_awvalid, m_wvalid, awready[0], awready[1],
                                          bvalid[0], bvalid[1]}));
    @(posedge clk);
    #2;
    fork
      run_port(0);
      run_port(1);
    join
    check_val("Lite write count", 48'(total), 48'(wr_log.size()));
    check_val("unwritten beats", 48'(0), 48'(exp_w0.size() + exp_w1.size()));
    repeat (5) begin
      @(negedge clk);
      check_val("extra B", 48'(0), 48'({bvalid[0], bvalid[1]}));
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

/* test/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
  output logic clk
);

  // 40 ns period.
  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

endmodule
